/* hw/dispatch_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_ctrl (
    input  wire logic                              CLK,
    input  wire logic                              nRST,
    input  wire logic                              in_valid,
    output logic                                   in_ready,
    input  wire dispatch_pkg::decoded_t            dec,
    input  wire dispatch_pkg::tag_t                rd_tag,
    input  wire dispatch_pkg::tag_t                rs1_tag,
    input  wire dispatch_pkg::tag_t                rs2_tag,
    input  wire logic [dispatch_pkg::NUM_FU-1:0]   busy,
    input  wire logic [dispatch_pkg::NUM_FU-1:0]   issuing,
    input  wire dispatch_pkg::wb_t                 wb,
    input  wire logic                              branch_resolved,
    input  wire logic                              branch_miss,
    output logic                                   set_en,
    output dispatch_pkg::reg_idx_t                 set_reg,
    output dispatch_pkg::tag_t                     set_tag,
    output logic                                   set_spec,
    output logic                                   wr_en,
    output dispatch_pkg::fu_op_t                   wr_op,
    output logic                                   halted
);

    import dispatch_pkg::*;

    logic spec_q;
    logic halt_q;
    logic struct_haz;
    logic waw;
    logic writes_rd;
    logic accept;
    logic spec_now;
    tag_t t1;
    tag_t t2;

    // the target unit is only free this cycle if its op is leaving
    always_comb begin
        struct_haz = 1'b0;
        if (dec.fu != FU_NONE) begin
            struct_haz = busy[dec.fu] && !issuing[dec.fu];
        end
    end

    // r0 is never tracked so writes to it carry no WAW risk
    assign writes_rd = dec.reg_write && dec.rd != '0;
    assign waw       = writes_rd && rd_tag != TAG_NONE;
    assign in_ready  = !(struct_haz || waw || halt_q || branch_miss);
    assign accept    = in_valid && in_ready;

    // new work is not speculative once the branch it follows resolves
    assign spec_now  = spec_q && !branch_resolved;

    // a writeback this cycle is not yet visible in the status table
    assign t1 = (wb.en && wb.rd == dec.rs1 && wb.tag == rs1_tag) ? TAG_NONE : rs1_tag;
    assign t2 = (wb.en && wb.rd == dec.rs2 && wb.tag == rs2_tag) ? TAG_NONE : rs2_tag;

    always_comb begin
        case (dec.fu)
            FU_ALU:    set_tag = TAG_ALU;
            FU_LD_ST:  set_tag = TAG_LD;
            FU_BRANCH: set_tag = TAG_BR;
            default:   set_tag = TAG_NONE;
        endcase
    end

    assign set_en   = accept && writes_rd;
    assign set_reg  = dec.rd;
    assign set_spec = spec_now;

    assign wr_en = accept && dec.fu != FU_NONE;
    assign wr_op = '{dec: dec, t1: t1, t2: t2, spec: spec_now};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec_q <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            if (branch_resolved || branch_miss) begin
                spec_q <= 1'b0;
            end else if (accept && dec.is_branch) begin
                spec_q <= 1'b1;
            end
            // a halt behind a mispredicted branch is discarded with it
            if (branch_miss) begin
                halt_q <= 1'b0;
            end else if (accept && dec.is_halt) begin
                halt_q <= 1'b1;
            end
        end
    end

    assign halted = halt_q;

endmodule

`default_nettype wire

/* hw/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    localparam int WORD_W   = 32;
    localparam int NUM_REGS = 32;
    localparam int NUM_FU   = 3;

    typedef logic [4:0] reg_idx_t;

    // the value of a unit doubles as its index into the FU status table
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LD_ST  = 2'd1,
        FU_BRANCH = 2'd2,
        FU_NONE   = 2'd3
    } fu_t;

    // names the unit that will write a register and is TAG_NONE once the value is ready
    typedef enum logic [1:0] {
        TAG_NONE = 2'd0,
        TAG_ALU  = 2'd1,
        TAG_BR   = 2'd2,
        TAG_LD   = 2'd3
    } tag_t;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_HALT   = 7'b1111111
    } opcode_t;

    typedef struct packed {
        fu_t               fu;
        reg_idx_t          rd;
        reg_idx_t          rs1;
        reg_idx_t          rs2;
        logic [WORD_W-1:0] imm;
        logic              reg_write;
        logic              is_branch;
        logic              is_halt;
    } decoded_t;

    // one entry of the FU status table
    typedef struct packed {
        decoded_t dec;
        tag_t     t1;
        tag_t     t2;
        logic     spec;
    } fu_op_t;

    typedef struct packed {
        fu_t               fu;
        reg_idx_t          rd;
        reg_idx_t          rs1;
        reg_idx_t          rs2;
        logic [WORD_W-1:0] imm;
        logic              spec;
    } issue_t;

    // writeback broadcast where rd is the register that was written
    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        tag_t     tag;
    } wb_t;

endpackage

`default_nettype wire

/* hw/dispatch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_top #(
    parameter int NUM_REGS = dispatch_pkg::NUM_REGS
) (
    input  wire logic                              CLK,
    input  wire logic                              nRST,
    input  wire logic                              in_valid,
    input  wire logic [dispatch_pkg::WORD_W-1:0]   in_instr,
    output logic                                   in_ready,
    output logic                                   exec_valid,
    output dispatch_pkg::issue_t                   exec_op,
    input  wire logic                              exec_ready,
    input  wire dispatch_pkg::wb_t                 wb,
    input  wire logic                              branch_resolved,
    input  wire logic                              branch_miss,
    output logic                                   halted
);

    import dispatch_pkg::*;

    decoded_t          dec;
    tag_t              rd_tag;
    tag_t              rs1_tag;
    tag_t              rs2_tag;
    logic [NUM_FU-1:0] busy;
    logic [NUM_FU-1:0] issuing;
    logic              set_en;
    reg_idx_t          set_reg;
    tag_t              set_tag;
    logic              set_spec;
    logic              wr_en;
    fu_op_t            wr_op;

    instr_decoder i_dec (
        .instr (in_instr),
        .dec   (dec)
    );

    reg_status_table #(
        .NUM_REGS (NUM_REGS)
    ) i_rst (
        .CLK             (CLK),
        .nRST            (nRST),
        .set_en          (set_en),
        .set_reg         (set_reg),
        .set_tag         (set_tag),
        .set_spec        (set_spec),
        .wb              (wb),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .rd_q            (dec.rd),
        .rs1_q           (dec.rs1),
        .rs2_q           (dec.rs2),
        .rd_tag          (rd_tag),
        .rs1_tag         (rs1_tag),
        .rs2_tag         (rs2_tag)
    );

    fu_status_table i_fust (
        .CLK             (CLK),
        .nRST            (nRST),
        .wr_en           (wr_en),
        .wr_op           (wr_op),
        .wb              (wb),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .busy            (busy),
        .issuing         (issuing),
        .exec_valid      (exec_valid),
        .exec_op         (exec_op),
        .exec_ready      (exec_ready)
    );

    dispatch_ctrl i_ctrl (
        .CLK             (CLK),
        .nRST            (nRST),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .dec             (dec),
        .rd_tag          (rd_tag),
        .rs1_tag         (rs1_tag),
        .rs2_tag         (rs2_tag),
        .busy            (busy),
        .issuing         (issuing),
        .wb              (wb),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .set_en          (set_en),
        .set_reg         (set_reg),
        .set_tag         (set_tag),
        .set_spec        (set_spec),
        .wr_en           (wr_en),
        .wr_op           (wr_op),
        .halted          (halted)
    );

endmodule

`default_nettype wire

/* hw/fu_status_table.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_status_table (
    input  wire logic                              CLK,
    input  wire logic                              nRST,
    input  wire logic                              wr_en,
    input  wire dispatch_pkg::fu_op_t              wr_op,
    input  wire dispatch_pkg::wb_t                 wb,
    input  wire logic                              branch_resolved,
    input  wire logic                              branch_miss,
    output logic [dispatch_pkg::NUM_FU-1:0]        busy,
    output logic [dispatch_pkg::NUM_FU-1:0]        issuing,
    output logic                                   exec_valid,
    output dispatch_pkg::issue_t                   exec_op,
    input  wire logic                              exec_ready
);

    import dispatch_pkg::*;

    fu_op_t              ent_q [NUM_FU];
    logic [NUM_FU-1:0]   busy_q;
    logic [NUM_FU-1:0]   issued_q;
    logic [NUM_FU-1:0]   ready;
    fu_t                 slot_fu;
    fu_t                 pick;
    logic                pick_valid;
    logic                slot_load;
    logic                handshake;
    issue_t              pick_op;

    // clears source tags hit by a writeback and the spec bit on a resolve
    function automatic fu_op_t refresh(fu_op_t op, wb_t w, logic resolved);
        fu_op_t r;
        r = op;
        if (w.en && w.rd == op.dec.rs1 && w.tag == op.t1) begin
            r.t1 = TAG_NONE;
        end
        if (w.en && w.rd == op.dec.rs2 && w.tag == op.t2) begin
            r.t2 = TAG_NONE;
        end
        if (resolved) begin
            r.spec = 1'b0;
        end
        return r;
    endfunction

    assign handshake = exec_valid && exec_ready;
    assign slot_load = !exec_valid || exec_ready;
    assign busy      = busy_q;

    always_comb begin
        for (int u = 0; u < NUM_FU; u++) begin
            ready[u]   = busy_q[u] && !issued_q[u] &&
                         ent_q[u].t1 == TAG_NONE && ent_q[u].t2 == TAG_NONE;
            issuing[u] = handshake && slot_fu == u;
        end
    end

    // walk down so that the lowest unit, the ALU, wins
    always_comb begin
        pick       = FU_ALU;
        pick_valid = 1'b0;
        for (int u = NUM_FU - 1; u >= 0; u--) begin
            if (ready[u]) begin
                pick       = fu_t'(u);
                pick_valid = 1'b1;
            end
        end
    end

    always_comb begin
        pick_op.fu   = ent_q[pick].dec.fu;
        pick_op.rd   = ent_q[pick].dec.rd;
        pick_op.rs1  = ent_q[pick].dec.rs1;
        pick_op.rs2  = ent_q[pick].dec.rs2;
        pick_op.imm  = ent_q[pick].dec.imm;
        pick_op.spec = ent_q[pick].spec && !branch_resolved;
    end

    always_ff @(posedge CLK) begin
        for (int u = 0; u < NUM_FU; u++) begin
            if (wr_en && wr_op.dec.fu == u) begin
                ent_q[u] <= refresh(wr_op, wb, branch_resolved);
            end else begin
                ent_q[u] <= refresh(ent_q[u], wb, branch_resolved);
            end
        end
        if (slot_load && pick_valid) begin
            exec_op <= pick_op;
            slot_fu <= pick;
        end else if (branch_resolved) begin
            exec_op.spec <= 1'b0;
        end
    end

    // an entry stays busy from dispatch until its op leaves the output slot
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q     <= '0;
            issued_q   <= '0;
            exec_valid <= 1'b0;
        end else begin
            if (slot_load) begin
                exec_valid <= pick_valid;
                if (pick_valid) begin
                    issued_q[pick] <= 1'b1;
                end
            end
            for (int u = 0; u < NUM_FU; u++) begin
                if (issuing[u]) begin
                    busy_q[u]   <= 1'b0;
                    issued_q[u] <= 1'b0;
                end
                if (wr_en && wr_op.dec.fu == u) begin
                    busy_q[u]   <= 1'b1;
                    issued_q[u] <= 1'b0;
                end
                if (branch_miss && ent_q[u].spec) begin
                    busy_q[u]   <= 1'b0;
                    issued_q[u] <= 1'b0;
                end
            end
            // a wrong-path op never reaches execute, even when already in the slot
            if (branch_miss && (slot_load ? pick_valid && pick_op.spec
                                          : exec_op.spec)) begin
                exec_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire logic [dispatch_pkg::WORD_W-1:0] instr,
    output dispatch_pkg::decoded_t               dec
);

    import dispatch_pkg::*;

    opcode_t           op;
    logic [WORD_W-1:0] imm_i;
    logic [WORD_W-1:0] imm_s;
    logic [WORD_W-1:0] imm_b;
    logic [WORD_W-1:0] imm_j;

    assign op = opcode_t'(instr[6:0]);

    // sign extended immediates of the RISC-V formats in use
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // register fields an opcode does not use are forced to zero
    // so that r0 never creates a dependency in the status tables
    always_comb begin
        dec           = '0;
        dec.fu        = FU_NONE;
        dec.rd        = instr[11:7];
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        case (op)
            OP_R: begin
                dec.fu        = FU_ALU;
                dec.reg_write = 1'b1;
            end
            OP_I: begin
                dec.fu        = FU_ALU;
                dec.reg_write = 1'b1;
                dec.rs2       = '0;
                dec.imm       = imm_i;
            end
            OP_LOAD: begin
                dec.fu        = FU_LD_ST;
                dec.reg_write = 1'b1;
                dec.rs2       = '0;
                dec.imm       = imm_i;
            end
            OP_STORE: begin
                dec.fu        = FU_LD_ST;
                dec.rd        = '0;
                dec.imm       = imm_s;
            end
            OP_BRANCH: begin
                dec.fu        = FU_BRANCH;
                dec.is_branch = 1'b1;
                dec.rd        = '0;
                dec.imm       = imm_b;
            end
            OP_JAL: begin
                dec.fu        = FU_BRANCH;
                dec.reg_write = 1'b1;
                dec.rs1       = '0;
                dec.rs2       = '0;
                dec.imm       = imm_j;
            end
            OP_JALR: begin
                dec.fu        = FU_BRANCH;
                dec.reg_write = 1'b1;
                dec.rs2       = '0;
                dec.imm       = imm_i;
            end
            OP_HALT: begin
                dec.is_halt   = 1'b1;
                dec.rd        = '0;
                dec.rs1       = '0;
                dec.rs2       = '0;
            end
            default: begin
                // unknown opcodes pass through as a nop
                dec.rd        = '0;
                dec.rs1       = '0;
                dec.rs2       = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/reg_status_table.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_status_table #(
    parameter int NUM_REGS = dispatch_pkg::NUM_REGS
) (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire logic                   set_en,
    input  wire dispatch_pkg::reg_idx_t set_reg,
    input  wire dispatch_pkg::tag_t     set_tag,
    input  wire logic                   set_spec,
    input  wire dispatch_pkg::wb_t      wb,
    input  wire logic                   branch_resolved,
    input  wire logic                   branch_miss,
    input  wire dispatch_pkg::reg_idx_t rd_q,
    input  wire dispatch_pkg::reg_idx_t rs1_q,
    input  wire dispatch_pkg::reg_idx_t rs2_q,
    output dispatch_pkg::tag_t          rd_tag,
    output dispatch_pkg::tag_t          rs1_tag,
    output dispatch_pkg::tag_t          rs2_tag
);

    import dispatch_pkg::*;

    tag_t                tag_q [NUM_REGS];
    logic [NUM_REGS-1:0] spec_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec_q <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                tag_q[i] <= TAG_NONE;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (branch_miss && spec_q[i]) begin
                    // the writer was on the wrong path and will never write back
                    tag_q[i]  <= TAG_NONE;
                    spec_q[i] <= 1'b0;
                end else if (set_en && set_reg == i) begin
                    tag_q[i]  <= set_tag;
                    spec_q[i] <= set_spec;
                end else if (wb.en && wb.rd == i && wb.tag == tag_q[i]) begin
                    tag_q[i]  <= TAG_NONE;
                    spec_q[i] <= 1'b0;
                end else if (branch_resolved) begin
                    spec_q[i] <= 1'b0;
                end
            end
        end
    end

    // lookups see the table before this cycle's updates
    assign rd_tag  = tag_q[rd_q];
    assign rs1_tag = tag_q[rs1_q];
    assign rs2_tag = tag_q[rs2_q];

endmodule

`default_nettype wire

/* test/tb_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dispatch;

    import dispatch_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int ACCEPT_LIMIT = 20;
    localparam int DRAIN_LIMIT  = 20;
    // worst case of each part of the run, with every wait running to its limit
    localparam int DECODE_CYCLES   = 20 * (ACCEPT_LIMIT + DRAIN_LIMIT + 2);
    localparam int DIRECTED_CYCLES = 5 * (4 * ACCEPT_LIMIT + 2 * DRAIN_LIMIT + 30);
    localparam int WATCHDOG_NS     = 2 * CLK_PERIOD * (5 + DECODE_CYCLES + DIRECTED_CYCLES);

    logic        CLK = 1'b0;
    logic        nRST;
    logic        in_valid;
    logic [31:0] in_instr;
    logic        in_ready;
    logic        exec_valid;
    issue_t      exec_op;
    logic        exec_ready;
    wb_t         wb;
    logic        branch_resolved;
    logic        branch_miss;
    logic        halted;

    issue_t expected_q[$];
    issue_t expected_op;
    string  cur_test = "reset";
    int     error_count = 0;
    int     errors_at_start = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     issue_count = 0;

    dispatch_top #(
        .NUM_REGS (NUM_REGS)
    ) i_dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .in_valid        (in_valid),
        .in_instr        (in_instr),
        .in_ready        (in_ready),
        .exec_valid      (exec_valid),
        .exec_op         (exec_op),
        .exec_ready      (exec_ready),
        .wb              (wb),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .halted          (halted)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // expected issue fields of a fetched word, per RISC-V format
    function automatic issue_t decode_ref(input logic [31:0] w);
        issue_t r;
        r     = '0;
        r.fu  = FU_NONE;
        r.rd  = w[11:7];
        r.rs1 = w[19:15];
        r.rs2 = w[24:20];
        case (w[6:0])
            OP_R: r.fu = FU_ALU;
            OP_I, OP_LOAD, OP_JALR: begin
                r.fu  = (w[6:0] == OP_I) ? FU_ALU : (w[6:0] == OP_LOAD) ? FU_LD_ST : FU_BRANCH;
                r.rs2 = '0;
                r.imm = {{20{w[31]}}, w[31:20]};
            end
            OP_STORE: begin
                r.fu  = FU_LD_ST;
                r.rd  = '0;
                r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OP_BRANCH: begin
                r.fu  = FU_BRANCH;
                r.rd  = '0;
                r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OP_JAL: begin
                r.fu  = FU_BRANCH;
                r.rs1 = '0;
                r.rs2 = '0;
                r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                r.rd  = '0;
                r.rs1 = '0;
                r.rs2 = '0;
            end
        endcase
        return r;
    endfunction

    function automatic logic writes_reg(input logic [31:0] w);
        return w[6:0] inside {OP_R, OP_I, OP_LOAD, OP_JAL, OP_JALR};
    endfunction

    function automatic tag_t tag_for(input fu_t fu);
        case (fu)
            FU_ALU:    return TAG_ALU;
            FU_LD_ST:  return TAG_LD;
            FU_BRANCH: return TAG_BR;
            default:   return TAG_NONE;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input reg_idx_t rd,
                                          input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input reg_idx_t rs1, input reg_idx_t rs2,
                                          input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    // kind 0 is ALU, 1 load, 2 store, 3 a branch or jump
    function automatic logic [31:0] random_word(input int kind);
        logic [31:0] w;
        int          pick;
        w    = $urandom();
        pick = $urandom() % 3;
        case (kind)
            0:       w[6:0] = (pick == 0) ? OP_R : OP_I;
            1:       w[6:0] = OP_LOAD;
            2:       w[6:0] = OP_STORE;
            default: w[6:0] = (pick == 0) ? OP_BRANCH : (pick == 1) ? OP_JAL : OP_JALR;
        endcase
        return w;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic report_error(input string text);
        $display("ERROR in %s: %s", cur_test, text);
        error_count++;
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: passed", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // called just after a falling edge and returns at a falling edge
    task automatic wait_accept(input logic [31:0] w, input logic expect_issue,
                               output int waited);
        waited = 0;
        @(posedge CLK);
        while (!in_ready && waited < ACCEPT_LIMIT) begin
            waited++;
            @(posedge CLK);
        end
        if (!in_ready) begin
            report_error($sformatf("word %h was not accepted within %0d cycles", w, waited));
        end else if (expect_issue) begin
            expected_q.push_back(decode_ref(w));
        end
        @(negedge CLK);
        in_valid = 1'b0;
    endtask

    task automatic send(input logic [31:0] w, input logic expect_issue, output int waited);
        in_instr = w;
        in_valid = 1'b1;
        wait_accept(w, expect_issue, waited);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expected_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (expected_q.size() != 0) begin
            report_error($sformatf("%0d expected operations were never issued",
                                   expected_q.size()));
            expected_q.delete();
        end
    endtask

    task automatic writeback(input reg_idx_t r, input tag_t t);
        wb = '{en: 1'b1, rd: r, tag: t};
        @(negedge CLK);
        wb = '0;
    endtask

    // plays execute finishing a word by writing back its result and resolving any branch
    task automatic retire(input logic [31:0] w);
        issue_t d;
        d = decode_ref(w);
        if (writes_reg(w) && d.rd != '0) begin
            wb = '{en: 1'b1, rd: d.rd, tag: tag_for(d.fu)};
        end
        branch_resolved = 1'b1;
        @(negedge CLK);
        wb              = '0;
        branch_resolved = 1'b0;
    endtask

    // every execute handshake must match the oldest expected operation
    always @(posedge CLK) begin
        if (nRST && exec_valid && exec_ready) begin
            issue_count++;
            if (expected_q.size() == 0) begin
                report_error($sformatf("operation %h issued with none expected", exec_op));
            end else begin
                expected_op = expected_q.pop_front();
                check_value("exec_op", 64'(expected_op), 64'(exec_op));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int          waited;
        int          seed_result;
        int          issued_before;
        logic [31:0] w;
        logic [31:0] alu_word;

        seed_result     = $urandom(29369);
        nRST            = 1'b0;
        in_valid        = 1'b0;
        in_instr        = '0;
        exec_ready      = 1'b1;
        wb              = '0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        repeat (5) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);

        begin_test("decode");
        check_value("in_ready after reset", 1, in_ready);
        check_value("exec_valid after reset", 0, exec_valid);
        check_value("halted after reset", 0, halted);
        for (int i = 0; i < 20; i++) begin
            w = random_word(i % 4);
            send(w, 1'b1, waited);
            wait_drain();
            retire(w);
        end
        check_value("issue count", 20, issue_count);
        end_test();

        begin_test("raw_wait");
        send(enc_i(OP_I, 5, 1, 12'h003), 1'b1, waited);
        w = enc_i(OP_LOAD, 6, 5, 12'h008);
        send(w, 1'b1, waited);
        repeat (6) @(negedge CLK);
        // the ALU op has left while the load still waits on r5
        check_value("ops still expected", 1, expected_q.size());
        writeback(5, TAG_ALU);
        wait_drain();
        retire(w);
        end_test();

        begin_test("waw_stall");
        send(enc_i(OP_LOAD, 7, 2, 12'h010), 1'b1, waited);
        w        = enc_r(7, 3, 4);
        in_instr = w;
        in_valid = 1'b1;
        repeat (10) begin
            @(posedge CLK);
            check_value("in_ready during WAW", 0, in_ready);
        end
        @(negedge CLK);
        writeback(7, TAG_LD);
        wait_accept(w, 1'b1, waited);
        check_value("wait cycles after writeback", 0, waited);
        wait_drain();
        retire(w);
        end_test();

        begin_test("structural_backpressure");
        exec_ready = 1'b0;
        alu_word   = enc_r(8, 1, 2);
        send(alu_word, 1'b1, waited);
        w        = enc_i(OP_I, 9, 1, 12'h005);
        in_instr = w;
        in_valid = 1'b1;
        repeat (6) begin
            @(posedge CLK);
            check_value("in_ready with ALU held", 0, in_ready);
        end
        check_value("exec_valid held", 1, exec_valid);
        check_value("exec_op held", 64'(decode_ref(alu_word)), 64'(exec_op));
        @(negedge CLK);
        exec_ready = 1'b1;
        wait_accept(w, 1'b1, waited);
        check_value("wait cycles after handshake", 0, waited);
        wait_drain();
        retire(alu_word);
        retire(w);
        end_test();

        begin_test("branch_miss");
        exec_ready = 1'b0;
        send(enc_b(1, 2, 13'h010), 1'b1, waited);
        send(enc_r(10, 1, 2), 1'b0, waited);
        send(enc_i(OP_LOAD, 11, 1, 12'h004), 1'b0, waited);
        repeat (2) @(negedge CLK);
        issued_before = issue_count;
        branch_miss   = 1'b1;
        @(negedge CLK);
        branch_miss = 1'b0;
        exec_ready  = 1'b1;
        wait_drain();
        repeat (5) @(negedge CLK);
        // only the branch itself may leave
        check_value("issued after miss", 1, issue_count - issued_before);
        w = enc_r(10, 1, 2);
        send(w, 1'b1, waited);
        check_value("wait cycles for r10", 0, waited);
        alu_word = enc_i(OP_LOAD, 11, 1, 12'h004);
        send(alu_word, 1'b1, waited);
        check_value("wait cycles for r11", 0, waited);
        wait_drain();
        retire(w);
        retire(alu_word);
        end_test();

        begin_test("halt");
        send(32'hFFFF_FFFF, 1'b0, waited);
        check_value("halted after halt word", 1, halted);
        w        = enc_r(12, 1, 2);
        in_instr = w;
        in_valid = 1'b1;
        repeat (5) begin
            @(posedge CLK);
            check_value("in_ready while halted", 0, in_ready);
            check_value("halted", 1, halted);
        end
        @(negedge CLK);
        branch_miss = 1'b1;
        @(negedge CLK);
        branch_miss = 1'b0;
        check_value("halted after miss", 0, halted);
        send(w, 1'b1, waited);
        check_value("wait cycles after miss", 0, waited);
        wait_drain();
        retire(w);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d, operations issued %0d",
                 tests_run, tests_failed, error_count, issue_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/dispatch_pkg.sv
hw/instr_decoder.sv
hw/reg_status_table.sv
hw/fu_status_table.sv
hw/dispatch_ctrl.sv
hw/dispatch_top.sv
test/tb_dispatch.sv
